// ==== logic/tinker_isa_pkg.sv ====
package tinker_isa_pkg;

    parameter int XLEN       = 64;  // register and data width
    parameter int INSTR_W    = 32;  // one instruction word
    parameter int ADDR_W     = 32;  // byte address
    parameter int OPCODE_W   = 5;
    parameter int REG_ADDR_W = 5;
    parameter int LIT_W      = 12;  // L field
    parameter int REG_COUNT  = 32;

    // kept opcodes, tinker encodings
    typedef enum logic [OPCODE_W-1:0] {
        op_and    = 5'h00,
        op_or     = 5'h01,
        op_xor    = 5'h02,
        op_not    = 5'h03,  // rt ignored
        op_shftr  = 5'h04,
        op_shftri = 5'h05,
        op_shftl  = 5'h06,
        op_shftli = 5'h07,
        op_br     = 5'h08,  // pc = rd
        op_brr_rd = 5'h09,  // pc += rd
        op_brr_l  = 5'h0a,  // pc += sext(L)
        op_brnz   = 5'h0b,
        op_brgt   = 5'h0e,
        op_halt   = 5'h0f,
        op_load   = 5'h10,  // mov rd,(rs)(L)
        op_mov_rr = 5'h11,  // mov rd,rs
        op_mov_l  = 5'h12,  // mov rd,L
        op_store  = 5'h13,  // mov (rd)(L),rs
        op_add    = 5'h18,
        op_addi   = 5'h19,
        op_sub    = 5'h1a,
        op_subi   = 5'h1b,
        op_mul    = 5'h1c
    } opcode_e;

    // control carried down the pipe
    // all zero is a bubble, nothing downstream reacts to it
    typedef struct packed {
        logic reg_write;  // rd written in wb
        logic mem_read;   // load, wb takes memory data
        logic mem_write;  // store in mem
        logic is_branch;  // already resolved in decode
        logic halt;       // raises hlt at wb
    } ctrl_t;

endpackage

// ==== logic/tinker_pipe_pkg.sv ====
package tinker_pipe_pkg;

    import tinker_isa_pkg::*;

    // decode -> execute, also the id/ex register
    typedef struct packed {
        opcode_e               opcode;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [LIT_W-1:0]      lit;
        ctrl_t                 ctrl;
        logic [ADDR_W-1:0]     pc;      // of this instruction, for tracing
        logic [XLEN-1:0]       rd_val;  // file values read in decode
        logic [XLEN-1:0]       rs_val;
        logic [XLEN-1:0]       rt_val;
    } issue_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [XLEN-1:0]       alu_result;  // also the memory address
        logic [XLEN-1:0]       store_val;   // rs after forwarding
        logic [REG_ADDR_W-1:0] dest;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [XLEN-1:0]       mem_data;
        logic [XLEN-1:0]       alu_result;
        logic [REG_ADDR_W-1:0] dest;
    } mem_wb_t;

    // operand source in ex
    typedef enum logic [1:0] {
        from_file = 2'd0,  // value read in decode
        from_mem  = 2'd1,  // ex/mem alu result
        from_wb   = 2'd2   // writeback data
    } fwd_sel_e;

endpackage

// ==== logic/issue_if.sv ====
// decode to execute hand-off
// the stall level runs the other way
interface issue_if;

    import tinker_isa_pkg::*;
    import tinker_pipe_pkg::*;

    issue_t                issue;     // combinational decode output
    logic [REG_ADDR_W-1:0] src_rd;    // decode-stage source numbers
    logic [REG_ADDR_W-1:0] src_rs;
    logic [REG_ADDR_W-1:0] src_rt;
    logic [2:0]            src_used;  // {rd, rs, rt} read in ex
    logic                  stall;     // load-use, from back end

    modport front (
        output issue, src_rd, src_rs, src_rt, src_used,
        input  stall
    );

    modport back (
        input  issue, src_rd, src_rs, src_rt, src_used,
        output stall
    );

endinterface

// ==== logic/reg_read_if.sv ====
interface reg_read_if;

    import tinker_isa_pkg::*;

    logic [REG_ADDR_W-1:0] rd_addr;  // driven by decode
    logic [REG_ADDR_W-1:0] rs_addr;
    logic [REG_ADDR_W-1:0] rt_addr;
    logic [XLEN-1:0]       rd_data;  // same cycle
    logic [XLEN-1:0]       rs_data;
    logic [XLEN-1:0]       rt_data;

    modport client (output rd_addr, rs_addr, rt_addr, input rd_data, rs_data, rt_data);
    modport server (input rd_addr, rs_addr, rt_addr, output rd_data, rs_data, rt_data);

endinterface

// ==== logic/tinker_alu.sv ====
module tinker_alu (
    input  tinker_isa_pkg::opcode_e             opcode,
    input  logic [tinker_isa_pkg::XLEN-1:0]     rd_val,
    input  logic [tinker_isa_pkg::XLEN-1:0]     rs_val,
    input  logic [tinker_isa_pkg::XLEN-1:0]     rt_val,
    input  logic [tinker_isa_pkg::LIT_W-1:0]    lit,
    output logic [tinker_isa_pkg::XLEN-1:0]     result
);

    import tinker_isa_pkg::*;

    logic [XLEN-1:0] lit_zx;  // immediate forms
    logic [XLEN-1:0] lit_sx;  // address offsets

    assign lit_zx = {{(XLEN-LIT_W){1'b0}}, lit};
    assign lit_sx = {{(XLEN-LIT_W){lit[LIT_W-1]}}, lit};

    always_comb begin
        case (opcode)
            op_add:    result = rs_val + rt_val;
            op_addi:   result = rd_val + lit_zx;
            op_sub:    result = rs_val - rt_val;
            op_subi:   result = rd_val - lit_zx;
            op_mul:    result = rs_val * rt_val;  // low 64 bits kept
            op_and:    result = rs_val & rt_val;
            op_or:     result = rs_val | rt_val;
            op_xor:    result = rs_val ^ rt_val;
            op_not:    result = ~rs_val;
            op_shftr:  result = rs_val >> rt_val;  // logical
            op_shftri: result = rd_val >> lit_zx;
            op_shftl:  result = rs_val << rt_val;
            op_shftli: result = rd_val << lit_zx;
            op_mov_rr: result = rs_val;
            // only the low 12 bits change
            op_mov_l:  result = {rd_val[XLEN-1:LIT_W], lit};
            op_load:   result = rs_val + lit_sx;  // load address
            op_store:  result = rd_val + lit_sx;  // store address
            default:   result = '0;  // branches, halt
        endcase
    end

endmodule

// ==== logic/tinker_front_end.sv ====
module tinker_front_end #(
    parameter logic [tinker_isa_pkg::ADDR_W-1:0] RESET_PC = 32'h2000
) (
    input  logic                               clk,
    input  logic                               reset,
    issue_if.front                             iss,
    reg_read_if.client                         rf,
    output logic [tinker_isa_pkg::ADDR_W-1:0]  fetch_addr,
    input  logic [tinker_isa_pkg::INSTR_W-1:0] fetch_instr
);

    import tinker_isa_pkg::*;
    import tinker_pipe_pkg::*;

    logic [ADDR_W-1:0]     pc;
    logic [ADDR_W-1:0]     ifid_pc;
    logic [INSTR_W-1:0]    ifid_instr;
    logic                  ifid_valid;  // low = bubble
    opcode_e               opcode;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [LIT_W-1:0]      lit;
    ctrl_t                 ctrl;
    logic [2:0]            used;        // {rd, rs, rt}
    logic                  take_branch;
    logic [ADDR_W-1:0]     target;

    assign fetch_addr = pc;

    // field split
    assign opcode = opcode_e'(ifid_instr[INSTR_W-1 -: OPCODE_W]);
    assign rd     = ifid_instr[26:22];
    assign rs     = ifid_instr[21:17];
    assign rt     = ifid_instr[16:12];
    assign lit    = ifid_instr[LIT_W-1:0];

    assign rf.rd_addr = rd;
    assign rf.rs_addr = rs;
    assign rf.rt_addr = rt;

    // control bundle and operands read later in ex
    always_comb begin
        ctrl = '0;
        used = 3'b000;
        if (ifid_valid) begin
            case (opcode)
                op_add, op_sub, op_mul, op_and, op_or, op_xor, op_shftr, op_shftl: begin
                    ctrl.reg_write = 1'b1;
                    used           = 3'b011;
                end
                op_not, op_mov_rr: begin
                    ctrl.reg_write = 1'b1;
                    used           = 3'b010;
                end
                op_addi, op_subi, op_shftri, op_shftli, op_mov_l: begin
                    ctrl.reg_write = 1'b1;  // rd is source and dest
                    used           = 3'b100;
                end
                op_load: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.mem_read  = 1'b1;
                    used           = 3'b010;  // address from rs
                end
                op_store: begin
                    ctrl.mem_write = 1'b1;
                    used           = 3'b110;  // rd base, rs data
                end
                op_br, op_brr_rd, op_brr_l, op_brnz, op_brgt: ctrl.is_branch = 1'b1;
                op_halt: ctrl.halt = 1'b1;
                default: ctrl = '0;  // unknown opcode goes down inert
            endcase
        end
    end

    // branch decision on plain file data, no forwarding here
    always_comb begin
        take_branch = 1'b0;
        target      = rf.rd_data[ADDR_W-1:0];
        if (ctrl.is_branch) begin
            case (opcode)
                op_br:     take_branch = 1'b1;
                op_brr_rd: begin
                    take_branch = 1'b1;
                    target      = ifid_pc + rf.rd_data[ADDR_W-1:0];
                end
                op_brr_l:  begin
                    take_branch = 1'b1;
                    target      = ifid_pc + {{(ADDR_W-LIT_W){lit[LIT_W-1]}}, lit};
                end
                op_brnz:   take_branch = (rf.rs_data != '0);
                op_brgt:   take_branch = ($signed(rf.rs_data) > $signed(rf.rt_data));
                default:   take_branch = 1'b0;
            endcase
        end
    end

    // pc and if/id valid, both frozen by stall
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc         <= RESET_PC;
            ifid_valid <= 1'b0;
        end else if (!iss.stall) begin
            pc         <= take_branch ? target : pc + 32'd4;
            ifid_valid <= !take_branch;  // squash the slot behind a taken branch
        end
    end

    always_ff @(posedge clk) begin
        if (!iss.stall) begin
            ifid_pc    <= pc;
            ifid_instr <= fetch_instr;
        end
    end

    always_comb begin
        iss.issue.opcode = opcode;
        iss.issue.rd     = rd;
        iss.issue.rs     = rs;
        iss.issue.rt     = rt;
        iss.issue.lit    = lit;
        iss.issue.ctrl   = ctrl;
        iss.issue.pc     = ifid_pc;
        iss.issue.rd_val = rf.rd_data;
        iss.issue.rs_val = rf.rs_data;
        iss.issue.rt_val = rf.rt_data;
    end

    assign iss.src_rd   = rd;
    assign iss.src_rs   = rs;
    assign iss.src_rt   = rt;
    assign iss.src_used = used;

endmodule

// ==== logic/tinker_reg_file.sv ====
module tinker_reg_file (
    input  logic                                  clk,
    input  logic                                  reset,
    reg_read_if.server                            rd_port,
    input  logic                                  we,
    input  logic [tinker_isa_pkg::REG_ADDR_W-1:0] dest,
    input  logic [tinker_isa_pkg::XLEN-1:0]       data
);

    import tinker_isa_pkg::*;

    logic [XLEN-1:0] regs [REG_COUNT];

    // whole file clears, no preset registers
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[dest] <= data;
        end
    end

    // write-through, a same-cycle write wins over the stored value
    assign rd_port.rd_data = (we && dest == rd_port.rd_addr) ? data : regs[rd_port.rd_addr];
    assign rd_port.rs_data = (we && dest == rd_port.rs_addr) ? data : regs[rd_port.rs_addr];
    assign rd_port.rt_data = (we && dest == rd_port.rt_addr) ? data : regs[rd_port.rt_addr];

endmodule

// ==== logic/tinker_back_end.sv ====
module tinker_back_end (
    input  logic                                  clk,
    input  logic                                  reset,
    issue_if.back                                 iss,
    output logic [tinker_isa_pkg::ADDR_W-1:0]     data_addr,
    input  logic [tinker_isa_pkg::XLEN-1:0]       load_data,
    output logic                                  store_we,
    output logic [tinker_isa_pkg::XLEN-1:0]       store_data,
    output logic                                  wb_we,
    output logic [tinker_isa_pkg::REG_ADDR_W-1:0] wb_dest,
    output logic [tinker_isa_pkg::XLEN-1:0]       wb_data,
    output logic                                  hlt
);

    import tinker_isa_pkg::*;
    import tinker_pipe_pkg::*;

    issue_t          id_ex;
    ex_mem_t         ex_mem;
    mem_wb_t         mem_wb;
    fwd_sel_e        sel_rd;
    fwd_sel_e        sel_rs;
    fwd_sel_e        sel_rt;
    logic [XLEN-1:0] rd_op;  // operands after forwarding
    logic [XLEN-1:0] rs_op;
    logic [XLEN-1:0] rt_op;
    logic [XLEN-1:0] alu_out;

    // newest producer first, a load in ex/mem only has its address
    function automatic fwd_sel_e pick_src(input logic [REG_ADDR_W-1:0] r,
                                          input ex_mem_t em, input mem_wb_t mw);
        if (em.ctrl.reg_write && !em.ctrl.mem_read && em.dest == r) begin
            return from_mem;
        end
        if (mw.ctrl.reg_write && mw.dest == r) begin
            return from_wb;
        end
        return from_file;
    endfunction

    function automatic logic [XLEN-1:0] route(input fwd_sel_e sel, input logic [XLEN-1:0] file_val,
                                              input logic [XLEN-1:0] mem_val,
                                              input logic [XLEN-1:0] wb_val);
        case (sel)
            from_mem: return mem_val;
            from_wb:  return wb_val;
            default:  return file_val;
        endcase
    endfunction

    // load-use, decode waits one cycle
    assign iss.stall = id_ex.ctrl.mem_read &&
        ((iss.src_used[2] && iss.src_rd == id_ex.rd) ||
         (iss.src_used[1] && iss.src_rs == id_ex.rd) ||
         (iss.src_used[0] && iss.src_rt == id_ex.rd));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex <= '0;
        end else if (iss.stall) begin
            id_ex <= '0;  // bubble into ex
        end else begin
            id_ex <= iss.issue;
        end
    end

    // ex
    assign sel_rd = pick_src(id_ex.rd, ex_mem, mem_wb);
    assign sel_rs = pick_src(id_ex.rs, ex_mem, mem_wb);
    assign sel_rt = pick_src(id_ex.rt, ex_mem, mem_wb);
    assign rd_op  = route(sel_rd, id_ex.rd_val, ex_mem.alu_result, wb_data);
    assign rs_op  = route(sel_rs, id_ex.rs_val, ex_mem.alu_result, wb_data);
    assign rt_op  = route(sel_rt, id_ex.rt_val, ex_mem.alu_result, wb_data);

    tinker_alu alu0 (
        .opcode (id_ex.opcode),
        .rd_val (rd_op),
        .rs_val (rs_op),
        .rt_val (rt_op),
        .lit    (id_ex.lit),
        .result (alu_out)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem <= '0;
        end else begin
            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.alu_result <= alu_out;
            ex_mem.store_val  <= rs_op;  // mov (rd)(L),rs stores rs
            ex_mem.dest       <= id_ex.rd;
        end
    end

    // mem, one port for loads and stores
    assign data_addr  = ex_mem.alu_result[ADDR_W-1:0];
    assign store_we   = ex_mem.ctrl.mem_write;
    assign store_data = ex_mem.store_val;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_wb <= '0;
        end else begin
            mem_wb.ctrl       <= ex_mem.ctrl;
            mem_wb.mem_data   <= load_data;  // answer arrives same cycle
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.dest       <= ex_mem.dest;
        end
    end

    // wb
    assign wb_we   = mem_wb.ctrl.reg_write;
    assign wb_dest = mem_wb.dest;
    assign wb_data = mem_wb.ctrl.mem_read ? mem_wb.mem_data : mem_wb.alu_result;
    assign hlt     = mem_wb.ctrl.halt;  // everything older has retired by now

endmodule

// ==== logic/tinker_core.sv ====
module tinker_core #(
    parameter logic [tinker_isa_pkg::ADDR_W-1:0] RESET_PC = 32'h2000
) (
    input  logic                                  clk,
    input  logic                                  reset,
    output logic [tinker_isa_pkg::ADDR_W-1:0]     fetch_addr,
    input  logic [tinker_isa_pkg::INSTR_W-1:0]    fetch_instr,  // combinational answer
    output logic [tinker_isa_pkg::ADDR_W-1:0]     data_addr,
    input  logic [tinker_isa_pkg::XLEN-1:0]       load_data,    // combinational answer
    output logic                                  store_we,
    output logic [tinker_isa_pkg::XLEN-1:0]       store_data,
    output logic                                  wb_we,        // retirement trace
    output logic [tinker_isa_pkg::REG_ADDR_W-1:0] wb_dest,
    output logic [tinker_isa_pkg::XLEN-1:0]       wb_data,
    output logic                                  hlt
);

    issue_if    iss_bus ();
    reg_read_if rf_bus ();

    // fetch + decode
    tinker_front_end #(
        .RESET_PC (RESET_PC)
    ) front_end0 (
        .clk         (clk),
        .reset       (reset),
        .iss         (iss_bus.front),
        .rf          (rf_bus.client),
        .fetch_addr  (fetch_addr),
        .fetch_instr (fetch_instr)
    );

    // written from wb, read from decode
    tinker_reg_file reg_file0 (
        .clk     (clk),
        .reset   (reset),
        .rd_port (rf_bus.server),
        .we      (wb_we),
        .dest    (wb_dest),
        .data    (wb_data)
    );

    // ex, mem, wb
    tinker_back_end back_end0 (
        .clk        (clk),
        .reset      (reset),
        .iss        (iss_bus.back),
        .data_addr  (data_addr),
        .load_data  (load_data),
        .store_we   (store_we),
        .store_data (store_data),
        .wb_we      (wb_we),
        .wb_dest    (wb_dest),
        .wb_data    (wb_data),
        .hlt        (hlt)
    );

endmodule

// ==== tests/tinker_core_properties.sv ====
module tinker_core_properties #(
    parameter logic [tinker_isa_pkg::ADDR_W-1:0] RESET_PC = 32'h2000
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [tinker_isa_pkg::ADDR_W-1:0] fetch_addr,
    input  logic                              store_we,
    input  logic                              wb_we,
    input  logic                              hlt,
    input  logic                              stall,        // load-use level
    input  logic                              take_branch   // decode redirect
);

    // quiet outputs while reset holds
    reset_state: assert property (@(posedge clk)
        reset |-> (!store_we && !wb_we && !hlt && fetch_addr == RESET_PC))
        else $error("outputs not in reset state while reset is high");

    // and still in the first cycle after
    reset_release: assert property (@(posedge clk)
        $fell(reset) |-> (!store_we && !wb_we && !hlt && fetch_addr == RESET_PC))
        else $error("outputs not in reset state in the first cycle after reset");

    fetch_step: assert property (@(posedge clk) disable iff (reset)
        (!stall && !take_branch) |=> fetch_addr == $past(fetch_addr) + 32'd4)
        else $error("fetch address did not advance by one word");

    stall_hold: assert property (@(posedge clk) disable iff (reset)
        stall |=> $stable(fetch_addr))
        else $error("fetch address moved during a load-use stall");

    // load-use bubble reaches wb three cycles on
    stall_bubble: assert property (@(posedge clk) disable iff (reset)
        stall |-> ##3 !wb_we)
        else $error("load-use bubble raised wb_we");

    // squashed slot behind a taken branch reaches wb four cycles on
    squash_bubble: assert property (@(posedge clk) disable iff (reset)
        take_branch |-> ##4 !wb_we)
        else $error("slot behind a taken branch raised wb_we");

    halt_no_write: assert property (@(posedge clk) disable iff (reset)
        hlt |-> !wb_we)
        else $error("halt slot wrote a register");

endmodule

bind tinker_core tinker_core_properties #(
    .RESET_PC (RESET_PC)
) props0 (
    .clk         (clk),
    .reset       (reset),
    .fetch_addr  (fetch_addr),
    .store_we    (store_we),
    .wb_we       (wb_we),
    .hlt         (hlt),
    .stall       (iss_bus.stall),
    .take_branch (front_end0.take_branch)
);

// ==== tests/tinker_core_tb.sv ====
module tinker_core_tb;

    import tinker_isa_pkg::*;

    localparam logic [ADDR_W-1:0]  RESET_PC  = 32'h2000;
    localparam int                 MEM_WORDS = 256;
    localparam logic [INSTR_W-1:0] HALT_WORD = {op_halt, 27'd0};

    logic                  clk;
    logic                  reset;
    logic [ADDR_W-1:0]     fetch_addr;
    logic [INSTR_W-1:0]    fetch_instr;
    logic [ADDR_W-1:0]     data_addr;
    logic [XLEN-1:0]       load_data;
    logic                  store_we;
    logic [XLEN-1:0]       store_data;
    logic                  wb_we;
    logic [REG_ADDR_W-1:0] wb_dest;
    logic [XLEN-1:0]       wb_data;
    logic                  hlt;

    logic [INSTR_W-1:0]    imem [MEM_WORDS];
    logic [XLEN-1:0]       dmem [MEM_WORDS];
    logic [ADDR_W-1:0]     fetch_idx;
    logic [INSTR_W-1:0]    prog [$];
    string                 prog_tag [$];      // section name per instruction
    string                 section;
    logic [REG_ADDR_W-1:0] exp_dest [$];      // expected writeback trace
    logic [XLEN-1:0]       exp_data [$];
    string                 exp_tag [$];
    logic [ADDR_W-1:0]     exp_saddr [$];     // expected stores
    logic [XLEN-1:0]       exp_sdata [$];
    string                 exp_stag [$];
    integer                seed;
    int                    trace_errors;
    int                    store_errors;
    int                    other_errors;
    int                    cycles;
    int                    limit;
    logic                  done;

    tinker_core #(
        .RESET_PC (RESET_PC)
    ) dut0 (
        .clk         (clk),
        .reset       (reset),
        .fetch_addr  (fetch_addr),
        .fetch_instr (fetch_instr),
        .data_addr   (data_addr),
        .load_data   (load_data),
        .store_we    (store_we),
        .store_data  (store_data),
        .wb_we       (wb_we),
        .wb_dest     (wb_dest),
        .wb_data     (wb_data),
        .hlt         (hlt)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // memory model, both ports answer in the same cycle
    assign fetch_idx   = (fetch_addr - RESET_PC) >> 2;
    assign fetch_instr = (fetch_idx < MEM_WORDS) ? imem[fetch_idx[7:0]] : HALT_WORD;
    assign load_data   = dmem[data_addr[10:3]];

    // data words differ over the whole index
    function automatic logic [XLEN-1:0] fill_word(input int idx);
        return 64'h0123_4567_89ab_cdef ^ ({32'd0, idx} * 64'h0000_0000_9e37_79b9);
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                dmem[i] <= fill_word(i);
            end
        end else if (store_we) begin
            dmem[data_addr[10:3]] <= store_data;  // 8-byte words
        end
    end

    function automatic logic [LIT_W-1:0] rnd_lit();
        return LIT_W'($random(seed));
    endfunction

    task automatic emit(input opcode_e op, input logic [4:0] d, input logic [4:0] s,
                        input logic [4:0] t, input logic [LIT_W-1:0] l);
        prog.push_back({op, d, s, t, l});
        prog_tag.push_back(section);
    endtask

    // absolute branch through r22, target is the slot after the poison
    task automatic branch_abs(input opcode_e op, input logic [4:0] s, input logic [4:0] t);
        int at;
        at = prog.size();
        emit(op_mov_rr, 22, 23, 0, 0);
        emit(op_mov_l, 22, 0, 0, LIT_W'(4 * (at + 6)));
        emit(op_add, 24, 1, 2, 0);     // filler, keeps r22 three slots back
        emit(op_xor, 26, 24, 1, 0);
        emit(op, 22, s, t, 0);
        emit(op_mov_l, 20, 0, 0, 12'hbad);  // only retires if not taken
    endtask

    task automatic build_program();
        section = "setup";
        emit(op_mov_l, 23, 0, 0, RESET_PC[23:12]);
        emit(op_shftli, 23, 0, 0, 12);         // r23 = program base
        emit(op_mov_l, 25, 0, 0, 8);
        emit(op_mov_l, 1, 0, 0, rnd_lit());
        emit(op_shftli, 1, 0, 0, 12);
        emit(op_mov_l, 1, 0, 0, rnd_lit());
        emit(op_mov_l, 2, 0, 0, rnd_lit());
        emit(op_shftli, 2, 0, 0, 20);
        emit(op_mov_l, 2, 0, 0, rnd_lit());
        section = "alu_chain";                 // each reads the one or two before
        emit(op_add, 3, 1, 2, 0);
        emit(op_sub, 4, 3, 1, 0);
        emit(op_mul, 5, 4, 2, 0);
        emit(op_and, 6, 5, 3, 0);
        emit(op_or, 7, 6, 4, 0);
        emit(op_xor, 8, 7, 5, 0);
        emit(op_not, 9, 8, 0, 0);
        emit(op_mov_l, 10, 0, 0, 3);
        emit(op_shftr, 11, 9, 10, 0);
        emit(op_shftl, 12, 11, 10, 0);
        emit(op_addi, 12, 0, 0, rnd_lit());
        emit(op_subi, 12, 0, 0, rnd_lit());
        emit(op_shftri, 12, 0, 0, 2);
        emit(op_mov_rr, 13, 12, 0, 0);
        section = "load_store";
        emit(op_mov_l, 14, 0, 0, 12'h100);
        emit(op_store, 14, 13, 0, 12'h008);
        emit(op_load, 15, 14, 0, 12'h008);
        emit(op_add, 16, 15, 1, 0);            // load-use on rs
        emit(op_store, 14, 3, 0, 12'hff8);     // negative offset
        emit(op_load, 17, 14, 0, 12'hff8);
        emit(op_sub, 18, 1, 17, 0);            // load-use on rt
        emit(op_load, 19, 14, 0, 12'h010);     // untouched word
        emit(op_addi, 19, 0, 0, 1);            // load-use on rd
        section = "branch";
        emit(op_brr_l, 0, 0, 0, 12'h008);
        emit(op_mov_l, 20, 0, 0, 12'hbad);
        emit(op_brr_rd, 25, 0, 0, 0);
        emit(op_mov_l, 20, 0, 0, 12'hbad);
        branch_abs(op_br, 0, 0);
        branch_abs(op_brnz, 0, 0);             // r0 is zero, falls through
        branch_abs(op_brnz, 1, 0);
        branch_abs(op_brgt, 1, 2);
        branch_abs(op_brgt, 2, 1);             // one of the two is taken
        emit(op_halt, 0, 0, 0, 0);
    endtask

    // instruction-level model, one instruction per step
    task automatic run_model();
        logic [XLEN-1:0]   r [REG_COUNT];
        logic [XLEN-1:0]   m [MEM_WORDS];
        logic [ADDR_W-1:0] pc;
        logic [ADDR_W-1:0] next;
        logic [INSTR_W-1:0] ins;
        opcode_e           op;
        logic [4:0]        d;
        logic [4:0]        s;
        logic [4:0]        t;
        logic [LIT_W-1:0]  l;
        logic [XLEN-1:0]   zx;
        logic [XLEN-1:0]   sx;
        logic [XLEN-1:0]   res;
        logic [XLEN-1:0]   a;
        logic              wr;
        logic              halted;
        int                idx;
        for (int i = 0; i < REG_COUNT; i++) r[i] = '0;
        for (int i = 0; i < MEM_WORDS; i++) m[i] = fill_word(i);
        pc     = RESET_PC;
        halted = 1'b0;
        while (!halted) begin
            idx  = int'((pc - RESET_PC) >> 2);
            ins  = prog[idx];
            op   = opcode_e'(ins[31:27]);
            d    = ins[26:22];
            s    = ins[21:17];
            t    = ins[16:12];
            l    = ins[11:0];
            zx   = {52'd0, l};
            sx   = {{52{l[11]}}, l};
            next = pc + 32'd4;
            wr   = 1'b1;
            res  = '0;
            case (op)
                op_add:    res = r[s] + r[t];
                op_addi:   res = r[d] + zx;
                op_sub:    res = r[s] - r[t];
                op_subi:   res = r[d] - zx;
                op_mul:    res = r[s] * r[t];
                op_and:    res = r[s] & r[t];
                op_or:     res = r[s] | r[t];
                op_xor:    res = r[s] ^ r[t];
                op_not:    res = ~r[s];
                op_shftr:  res = r[s] >> r[t];
                op_shftri: res = r[d] >> zx;
                op_shftl:  res = r[s] << r[t];
                op_shftli: res = r[d] << zx;
                op_mov_rr: res = r[s];
                op_mov_l:  res = {r[d][63:12], l};  // low 12 bits replaced
                op_load: begin
                    a   = r[s] + sx;
                    res = m[a[10:3]];
                end
                op_store: begin
                    a  = r[d] + sx;
                    wr = 1'b0;
                    m[a[10:3]] = r[s];
                    exp_saddr.push_back(a[31:0]);
                    exp_sdata.push_back(r[s]);
                    exp_stag.push_back(prog_tag[idx]);
                end
                op_br:     begin wr = 1'b0; next = r[d][31:0]; end
                op_brr_rd: begin wr = 1'b0; next = pc + r[d][31:0]; end
                op_brr_l:  begin wr = 1'b0; next = pc + {{20{l[11]}}, l}; end
                op_brnz: begin
                    wr = 1'b0;
                    if (r[s] != '0) next = r[d][31:0];
                end
                op_brgt: begin
                    wr = 1'b0;
                    if ($signed(r[s]) > $signed(r[t])) next = r[d][31:0];
                end
                default: begin wr = 1'b0; halted = 1'b1; end
            endcase
            if (wr) begin
                r[d] = res;
                exp_dest.push_back(d);
                exp_data.push_back(res);
                exp_tag.push_back(prog_tag[idx]);
            end
            pc = next;
        end
    endtask

    task automatic check_writeback();
        if (exp_dest.size() == 0) begin
            other_errors++;
            $display("register r%0d written after the expected trace ended", wb_dest);
        end else begin
            assert (wb_dest == exp_dest[0] && wb_data == exp_data[0]) else begin
                trace_errors++;
                $display("CHECK FAILED %s expected r%0d=%h actual r%0d=%h",
                         exp_tag[0], exp_dest[0], exp_data[0], wb_dest, wb_data);
            end
            void'(exp_dest.pop_front());
            void'(exp_data.pop_front());
            void'(exp_tag.pop_front());
        end
    endtask

    task automatic check_store();
        if (exp_saddr.size() == 0) begin
            other_errors++;
            $display("store to %h that the program never makes", data_addr);
        end else begin
            assert (data_addr == exp_saddr[0] && store_data == exp_sdata[0]) else begin
                store_errors++;
                $display("CHECK FAILED %s expected [%h]=%h actual [%h]=%h",
                         exp_stag[0], exp_saddr[0], exp_sdata[0], data_addr, store_data);
            end
            void'(exp_saddr.pop_front());
            void'(exp_sdata.pop_front());
            void'(exp_stag.pop_front());
        end
    endtask

    initial begin
        seed         = 32;
        trace_errors = 0;
        store_errors = 0;
        other_errors = 0;
        cycles       = 0;
        done         = 1'b0;
        reset        = 1'b1;
        build_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : HALT_WORD;  // halts past the end
        end
        run_model();
        limit = 20 * prog.size() + 50;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        // outputs settle well before the falling edge
        while (!done && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (wb_we) check_writeback();
            if (store_we) check_store();
            if (hlt) begin
                done = 1'b1;
                assert (exp_dest.size() == 0 && exp_saddr.size() == 0) else begin
                    other_errors++;
                    $display("halt raised with %0d writes and %0d stores still missing",
                             exp_dest.size(), exp_saddr.size());
                end
            end
        end
        if (!done) begin
            other_errors++;
            $display("timeout, no halt within %0d cycles", limit);
        end
        $display("errors: trace %0d, store %0d, other %0d",
                 trace_errors, store_errors, other_errors);
        if (trace_errors + store_errors + other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
logic/tinker_isa_pkg.sv
logic/tinker_pipe_pkg.sv
logic/issue_if.sv
logic/reg_read_if.sv
logic/tinker_alu.sv
logic/tinker_front_end.sv
logic/tinker_reg_file.sv
logic/tinker_back_end.sv
logic/tinker_core.sv
tests/tinker_core_properties.sv
tests/tinker_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the tinker core testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tinker_core_tb -o tinker_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tinker_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^All checks passed$"; then
    exit 0
fi
exit 1
